// ==== rtl/chess_ctrl_defines.svh ====
`ifndef CHESS_CTRL_DEFINES_SVH
`define CHESS_CTRL_DEFINES_SVH

//==========================================================================
// bus and memory geometry
//==========================================================================
`define CC_DATA_W       32    // bus word
`define CC_ADDR_W       13    // word address, covers the whole RAM
`define CC_RAM_DEPTH    8192  // RAM entries

//==========================================================================
// address map
//==========================================================================
`define CC_CSR_WORDS    16    // 0..15 live in flops, never in RAM
`define CC_BOARD_LO     2     // board words 2..9, word 2 is the lsw
`define CC_COUNT_ADDR   16    // move count lands here
`define CC_LIST_BASE    17    // first move entry

// LMG FIFO layout
`define CC_SLOT_W       19    // top bit set means slot is empty/invalid
`define CC_SLOTS        8     // slots per fifo word
`define CC_FIFO_W       160
`define CC_MOVE_W       18    // move body without the invalid flag

// control word 0
`define CC_START_BIT    0
`define CC_DONE_BIT     1

`endif

// ==== rtl/chess_ctrl_pkg.sv ====
`include "chess_ctrl_defines.svh"

package chess_ctrl_pkg;

	typedef logic [`CC_ADDR_W-1:0]   bus_addr_t;
	typedef logic [`CC_DATA_W-1:0]   bus_data_t;
	typedef logic [8*`CC_DATA_W-1:0] board_t;      // words 2..9, word 2 at the bottom
	typedef logic [`CC_FIFO_W-1:0]   fifo_word_t;
	typedef logic [`CC_SLOT_W-1:0]   slot_t;       // msb is the invalid flag
	typedef logic [`CC_MOVE_W-1:0]   move_t;       // reformatted move
	typedef logic [7:0]              move_cnt_t;   // moves written this run

	typedef struct packed {
		logic      read;
		logic      write;
		bus_addr_t address;
		bus_data_t writedata;
	} bus_req_t;

	typedef struct packed {
		logic       en;
		logic [3:0] idx;   // register index 0..15
		bus_data_t  data;
	} csr_wr_t;

	typedef struct packed {
		logic      en;
		bus_addr_t addr;
		bus_data_t data;
	} ram_wr_t;

	// toward the LMG
	typedef struct packed {
		logic reset;   // single cycle
		logic rden;    // single cycle pop
	} lmg_ctrl_t;

	// from the LMG
	typedef struct packed {
		logic       done;        // level
		logic       empty;
		fifo_word_t fifo_word;   // valid from the cycle after rden
	} lmg_stat_t;

	typedef enum logic [2:0] {
		idle,
		reset_lmg,
		wait_done,
		pop,
		scan,
		write_count,
		write_term,
		finish
	} collect_state_e;

endpackage

// ==== rtl/csr_bank.sv ====
`include "chess_ctrl_defines.svh"

module csr_bank (
	input  logic                      clk,
	input  logic                      arst_n,
	input  chess_ctrl_pkg::csr_wr_t   csr_wr,
	input  logic [3:0]                rd_idx,      // index of this cycle's read
	input  logic                      list_done,   // pulse from the collector
	output chess_ctrl_pkg::bus_data_t csr_rdata,
	output logic                      start,
	output chess_ctrl_pkg::board_t    board
);

	localparam int BOARD_WORDS = $bits(chess_ctrl_pkg::board_t) / `CC_DATA_W;

	chess_ctrl_pkg::bus_data_t regs [`CC_CSR_WORDS];
	chess_ctrl_pkg::bus_data_t ctrl_next;   // word 0 after bus write and done update

	//==========================================================================
	// control word
	//==========================================================================
	always_comb begin
		ctrl_next = regs[0];
		if (csr_wr.en && csr_wr.idx == 4'd0) begin
			ctrl_next = csr_wr.data;
			ctrl_next[`CC_DONE_BIT] = regs[0][`CC_DONE_BIT]; // done is owned by hw
		end
		if (!ctrl_next[`CC_START_BIT]) begin
			ctrl_next[`CC_DONE_BIT] = 1'b0;   // no start, no done
		end else if (list_done) begin
			ctrl_next[`CC_DONE_BIT] = 1'b1;
		end
	end

	//==========================================================================
	// register file
	//==========================================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CC_CSR_WORDS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			regs[0] <= ctrl_next;
			for (int i = 1; i < `CC_CSR_WORDS; i++) begin
				if (csr_wr.en && csr_wr.idx == 4'(i)) begin
					regs[i] <= csr_wr.data;
				end
			end
		end
	end

	// readback one cycle behind the index, old value on a same-cycle write
	always_ff @(posedge clk) begin
		csr_rdata <= regs[rd_idx];
	end

	assign start = regs[0][`CC_START_BIT];

	// board is words 2..9, lowest address in the lowest bits
	always_comb begin
		for (int w = 0; w < BOARD_WORDS; w++) begin
			board[w*`CC_DATA_W +: `CC_DATA_W] = regs[`CC_BOARD_LO + w];
		end
	end

endmodule

// ==== rtl/move_collector.sv ====
`include "chess_ctrl_defines.svh"

module move_collector (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      start,      // level from control word 0
	input  chess_ctrl_pkg::lmg_stat_t lmg_stat,
	output chess_ctrl_pkg::lmg_ctrl_t lmg_ctrl,
	output chess_ctrl_pkg::ram_wr_t   ram_wr,
	output logic                      list_done   // one cycle, list is complete
);

	localparam int IDX_W = $clog2(`CC_SLOTS);

	chess_ctrl_pkg::collect_state_e state;
	chess_ctrl_pkg::collect_state_e state_next;

	logic                      start_q;     // start delayed for edge detect
	logic                      start_rise;
	logic [IDX_W-1:0]          slot_idx;    // slot being scanned
	logic                      last_slot;
	chess_ctrl_pkg::move_cnt_t count;       // valid moves written so far
	chess_ctrl_pkg::slot_t     slot;
	logic                      slot_ok;
	chess_ctrl_pkg::bus_addr_t list_addr;   // next free list entry

	// square halves swap, from/to kept in the same order
	function automatic chess_ctrl_pkg::move_t reformat(input chess_ctrl_pkg::slot_t s);
		return {s[17:12], s[8:6], s[11:9], s[2:0], s[5:3]};
	endfunction

	assign start_rise = start && !start_q;
	assign last_slot  = slot_idx == IDX_W'(`CC_SLOTS - 1);
	assign slot       = lmg_stat.fifo_word[slot_idx*`CC_SLOT_W +: `CC_SLOT_W];
	assign slot_ok    = !slot[`CC_SLOT_W-1];   // invalid flag clear
	assign list_addr  = chess_ctrl_pkg::bus_addr_t'(`CC_LIST_BASE)
		+ chess_ctrl_pkg::bus_addr_t'(count);

	//==========================================================================
	// sequencer
	//==========================================================================
	always_comb begin
		state_next = state;
		case (state)
			chess_ctrl_pkg::idle: begin
				if (start_rise) begin
					state_next = chess_ctrl_pkg::reset_lmg;
				end
			end
			chess_ctrl_pkg::reset_lmg: state_next = chess_ctrl_pkg::wait_done;
			chess_ctrl_pkg::wait_done: begin
				if (lmg_stat.done) begin
					state_next = chess_ctrl_pkg::pop;
				end
			end
			chess_ctrl_pkg::pop: state_next = chess_ctrl_pkg::scan; // word shows up next cycle
			chess_ctrl_pkg::scan: begin
				if (last_slot) begin   // empty is only looked at after slot 7
					state_next = lmg_stat.empty ? chess_ctrl_pkg::write_count
						: chess_ctrl_pkg::pop;
				end
			end
			chess_ctrl_pkg::write_count: state_next = chess_ctrl_pkg::write_term;
			chess_ctrl_pkg::write_term:  state_next = chess_ctrl_pkg::finish;
			chess_ctrl_pkg::finish:      state_next = chess_ctrl_pkg::idle;
			default:                     state_next = chess_ctrl_pkg::idle;
		endcase
		if (!start) begin
			state_next = chess_ctrl_pkg::idle;   // abort from anywhere
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= chess_ctrl_pkg::idle;
			start_q  <= 1'b0;
			slot_idx <= '0;
			count    <= '0;
		end else begin
			state   <= state_next;
			start_q <= start;

			if (state == chess_ctrl_pkg::pop) begin
				slot_idx <= '0;
			end else if (state == chess_ctrl_pkg::scan) begin
				slot_idx <= slot_idx + 1'b1;   // wraps to 0 after slot 7
			end

			if (start_rise) begin
				count <= '0;   // fresh list on every new start
			end else if (state == chess_ctrl_pkg::scan && slot_ok) begin
				count <= count + 1'b1;
			end
		end
	end

	//==========================================================================
	// outputs, decoded from state
	//==========================================================================
	always_comb begin
		lmg_ctrl.reset = state == chess_ctrl_pkg::reset_lmg;
		lmg_ctrl.rden  = state == chess_ctrl_pkg::pop;
		list_done      = state == chess_ctrl_pkg::finish;

		ram_wr.en   = 1'b0;
		ram_wr.addr = list_addr;
		ram_wr.data = chess_ctrl_pkg::bus_data_t'(reformat(slot));   // zero extended
		case (state)
			chess_ctrl_pkg::scan: ram_wr.en = slot_ok;   // invalid slots skipped
			chess_ctrl_pkg::write_count: begin
				ram_wr.en   = 1'b1;
				ram_wr.addr = chess_ctrl_pkg::bus_addr_t'(`CC_COUNT_ADDR);
				ram_wr.data = chess_ctrl_pkg::bus_data_t'(count);
			end
			chess_ctrl_pkg::write_term: begin
				ram_wr.en   = 1'b1;   // terminator right after the last move
				ram_wr.data = '0;
			end
			default: ram_wr.en = 1'b0;
		endcase
	end

endmodule

// ==== rtl/move_store.sv ====
`include "chess_ctrl_defines.svh"

module move_store (
	input  logic                      clk,
	input  logic                      arst_n,
	input  chess_ctrl_pkg::bus_req_t  bus,
	input  chess_ctrl_pkg::ram_wr_t   ram_wr,      // collector side, wins on conflict
	input  chess_ctrl_pkg::bus_data_t csr_rdata,
	output chess_ctrl_pkg::csr_wr_t   csr_wr,
	output logic [3:0]                rd_idx,
	output chess_ctrl_pkg::bus_data_t readdata,
	output logic                      readdatavalid
);

	chess_ctrl_pkg::bus_data_t mem [`CC_RAM_DEPTH];   // inferred block RAM
	chess_ctrl_pkg::bus_data_t ram_q;

	logic is_csr;       // address falls in the register window
	logic bus_ram_wr;
	logic rd_csr_q;     // previous read went to the registers

	//==========================================================================
	// decode
	//==========================================================================
	assign is_csr     = bus.address < chess_ctrl_pkg::bus_addr_t'(`CC_CSR_WORDS);
	assign bus_ram_wr = bus.write && !is_csr;
	assign rd_idx     = bus.address[3:0];

	always_comb begin
		csr_wr.en   = bus.write && is_csr;
		csr_wr.idx  = bus.address[3:0];
		csr_wr.data = bus.writedata;
	end

	//==========================================================================
	// RAM, collector write has priority, bus write dropped on a clash
	//==========================================================================
	always_ff @(posedge clk) begin
		if (ram_wr.en) begin
			mem[ram_wr.addr] <= ram_wr.data;
		end else if (bus_ram_wr) begin
			mem[bus.address] <= bus.writedata;
		end
		if (bus.read) begin
			ram_q <= mem[bus.address];   // old data on read during write
		end
	end

	//==========================================================================
	// read response, fixed latency of one
	//==========================================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			readdatavalid <= 1'b0;
			rd_csr_q      <= 1'b0;
		end else begin
			readdatavalid <= bus.read;
			if (bus.read) begin
				rd_csr_q <= is_csr;
			end
		end
	end

	assign readdata = rd_csr_q ? csr_rdata : ram_q;

endmodule

// ==== rtl/chess_ctrl_top.sv ====
module chess_ctrl_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  chess_ctrl_pkg::bus_req_t  bus,
	input  chess_ctrl_pkg::lmg_stat_t lmg_stat,
	output chess_ctrl_pkg::bus_data_t readdata,
	output logic                      readdatavalid,
	output chess_ctrl_pkg::lmg_ctrl_t lmg_ctrl,
	output chess_ctrl_pkg::board_t    board        // straight to the LMG
);

	//==========================================================================
	// internal nets
	//==========================================================================
	chess_ctrl_pkg::csr_wr_t   csr_wr;      // store -> register bank
	logic [3:0]                rd_idx;
	chess_ctrl_pkg::bus_data_t csr_rdata;   // register bank -> read mux
	logic                      start;
	logic                      list_done;   // collector -> done bit
	chess_ctrl_pkg::ram_wr_t   ram_wr;      // collector -> RAM

	csr_bank u_csr_bank (
		.clk       (clk),
		.arst_n    (arst_n),
		.csr_wr    (csr_wr),
		.rd_idx    (rd_idx),
		.list_done (list_done),
		.csr_rdata (csr_rdata),
		.start     (start),
		.board     (board)
	);

	move_collector u_move_collector (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start),
		.lmg_stat  (lmg_stat),
		.lmg_ctrl  (lmg_ctrl),
		.ram_wr    (ram_wr),
		.list_done (list_done)
	);

	move_store u_move_store (
		.clk           (clk),
		.arst_n        (arst_n),
		.bus           (bus),
		.ram_wr        (ram_wr),
		.csr_rdata     (csr_rdata),
		.csr_wr        (csr_wr),
		.rd_idx        (rd_idx),
		.readdata      (readdata),
		.readdatavalid (readdatavalid)
	);

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk;   // free running

endmodule

// ==== verification/chess_ctrl_checker.sv ====
module chess_ctrl_checker (
	input logic                      clk,
	input logic                      readdatavalid,
	input chess_ctrl_pkg::bus_data_t readdata,
	input chess_ctrl_pkg::lmg_ctrl_t lmg_ctrl,
	input chess_ctrl_pkg::board_t    board          // board port toward the LMG
);

	localparam int WORD_W = $bits(chess_ctrl_pkg::bus_data_t);

	string                     names [$];   // armed expectations in arrival order
	chess_ctrl_pkg::bus_data_t exps  [$];
	chess_ctrl_pkg::bus_data_t last_data;   // latest response seen by the done poll
	int resp_cnt  = 0;
	int rst_seen  = 0;   // lmg reset pulses
	int rden_seen = 0;   // lmg pops
	int pass_cnt  = 0;
	int fail_cnt  = 0;

	task automatic expect_read(input string name, input chess_ctrl_pkg::bus_data_t exp);
		names.push_back(name);
		exps.push_back(exp);
	endtask

	task automatic note_pass(input string name);
		pass_cnt++;
		$display("ok %s", name);
	endtask

	task automatic note_fail(input string name, input string what);
		fail_cnt++;
		$display("error %s: %s", name, what);
	endtask

	task automatic note_mismatch(input string name, input chess_ctrl_pkg::bus_data_t exp,
		input chess_ctrl_pkg::bus_data_t act);
		fail_cnt++;
		$display("mismatch %s expected %h actual %h", name, exp, act);
	endtask

	task automatic check_no_pulses(input string name);
		if (rst_seen == 0 && rden_seen == 0) note_pass(name);
		else note_fail(name, "the LMG saw a reset or read pulse while idle");
	endtask

	// one slice of the board port, slice 0 is the lowest board register
	task automatic check_board_word(input string name, input int idx,
		input chess_ctrl_pkg::bus_data_t exp);
		chess_ctrl_pkg::bus_data_t act;
		act = board[idx*WORD_W +: WORD_W];
		if (act === exp) note_pass(name);
		else note_mismatch(name, exp, act);
	endtask

	// sampled on the falling edge where outputs have settled
	always @(negedge clk) begin
		if (lmg_ctrl.reset) rst_seen++;
		if (lmg_ctrl.rden) rden_seen++;
		if (readdatavalid) begin
			last_data = readdata;
			if (names.size() > 0) begin
				if (readdata === exps[0]) begin
					note_pass(names[0]);
				end else begin
					note_mismatch(names[0], exps[0], readdata);
				end
				void'(names.pop_front());
				void'(exps.pop_front());
			end
			resp_cnt++;   // polling reads land here with nothing armed
		end
	end

endmodule

// ==== verification/chess_ctrl_properties.sv ====
module chess_ctrl_properties (
	input logic                      clk,
	input logic                      arst_n,
	input chess_ctrl_pkg::bus_req_t  bus,
	input logic                      readdatavalid,
	input chess_ctrl_pkg::lmg_ctrl_t lmg_ctrl,
	input logic                      list_done,
	input logic                      ram_wr_en
);

	// fixed read latency of one
	a_rdv_follows: assert property (@(posedge clk) disable iff (!arst_n)
		bus.read |=> readdatavalid) else $error("readdatavalid missing after a read");
	a_rdv_only: assert property (@(posedge clk) disable iff (!arst_n)
		!bus.read |=> !readdatavalid) else $error("readdatavalid without a read");

	a_rden_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		lmg_ctrl.rden |=> !lmg_ctrl.rden) else $error("lmg rden longer than a cycle");
	a_reset_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		lmg_ctrl.reset |=> !lmg_ctrl.reset) else $error("lmg reset longer than a cycle");

	a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !readdatavalid
		&& !lmg_ctrl.rden && !lmg_ctrl.reset && !list_done && !ram_wr_en)
		else $error("activity during reset");

endmodule

bind chess_ctrl_top chess_ctrl_properties props (
	.clk           (clk),
	.arst_n        (arst_n),
	.bus           (bus),
	.readdatavalid (readdatavalid),
	.lmg_ctrl      (lmg_ctrl),
	.list_done     (list_done),
	.ram_wr_en     (ram_wr.en)
);

// ==== verification/chess_ctrl_tb.sv ====
`include "chess_ctrl_defines.svh"

module chess_ctrl_tb #(
	parameter logic [31:0] SEED = 32'hba5a
);

	localparam int K_WRITE = 0;
	localparam int K_READ  = 1;
	localparam int K_RUN   = 2;
	localparam int K_STOP  = 3;
	localparam int K_BOARD = 4;   // compare one word of the board port

	typedef struct {
		string       name;
		int          kind;
		int          addr;
		logic [31:0] data;
		logic [31:0] exp;
		int          set;   // LMG word set used by a run
	} entry_t;

	logic clk;
	logic arst_n;
	chess_ctrl_pkg::bus_req_t  bus;
	chess_ctrl_pkg::lmg_stat_t lmg_stat;
	chess_ctrl_pkg::bus_data_t readdata;
	logic                      readdatavalid;
	chess_ctrl_pkg::lmg_ctrl_t lmg_ctrl;
	chess_ctrl_pkg::board_t    board;

	entry_t                     table_q [$];
	chess_ctrl_pkg::fifo_word_t words [3][4];   // LMG scenarios
	int                         n_words [3];
	int                         cur_set = 0;

	tb_clock #(.PERIOD(8)) u_clock (.clk(clk));

	chess_ctrl_top dut (
		.clk(clk), .arst_n(arst_n), .bus(bus), .lmg_stat(lmg_stat),
		.readdata(readdata), .readdatavalid(readdatavalid), .lmg_ctrl(lmg_ctrl), .board(board)
	);

	chess_ctrl_checker chk (
		.clk(clk), .readdatavalid(readdatavalid), .readdata(readdata), .lmg_ctrl(lmg_ctrl),
		.board(board)
	);

	// move format swaps the 3-bit halves of both squares
	function automatic logic [31:0] expect_move(input logic [18:0] s);
		logic [5:0] from_sq;
		logic [5:0] to_sq;
		from_sq = s[11:6];
		to_sq   = s[5:0];
		return {14'd0, s[17:12], from_sq[2:0], from_sq[5:3], to_sq[2:0], to_sq[5:3]};
	endfunction

	task automatic add_entry(input string name, input int kind, input int addr,
		input logic [31:0] data, input logic [31:0] exp, input int set);
		entry_t e;
		e.name = name;
		e.kind = kind;
		e.addr = addr;
		e.data = data;
		e.exp  = exp;
		e.set  = set;
		table_q.push_back(e);
	endtask

	// slot 0 always valid and slot 1 always invalid unless all_bad
	task automatic make_set(input int set, input int n, input bit all_bad);
		logic [18:0] s;
		n_words[set] = n;
		for (int w = 0; w < n; w++) begin
			for (int i = 0; i < `CC_SLOTS; i++) begin
				s = {1'b0, 18'($urandom)};
				if (all_bad || i == 1 || (i > 1 && $urandom % 3 == 0)) s[18] = 1'b1;
				words[set][w][i*`CC_SLOT_W +: `CC_SLOT_W] = s;
			end
		end
	endtask

	// expected list after a run is the moves in order, then count and terminator
	task automatic add_list_checks(input string tag, input int set);
		int          cnt;
		logic [18:0] s;
		cnt = 0;
		for (int w = 0; w < n_words[set]; w++) begin
			for (int i = 0; i < `CC_SLOTS; i++) begin
				s = words[set][w][i*`CC_SLOT_W +: `CC_SLOT_W];
				if (!s[18]) begin
					add_entry($sformatf("%s_move%0d", tag, cnt), K_READ,
						`CC_LIST_BASE + cnt, 0, expect_move(s), 0);
					cnt++;
				end
			end
		end
		add_entry({tag, "_count"}, K_READ, `CC_COUNT_ADDR, 0, cnt, 0);
		add_entry({tag, "_term"}, K_READ, `CC_LIST_BASE + cnt, 0, 0, 0);
	endtask

	task automatic build_table();
		logic [31:0] r;
		int          ram_addr [$];
		// junk over the list region so missing list writes show up
		for (int a = `CC_LIST_BASE; a <= `CC_LIST_BASE + 2 * `CC_SLOTS; a++) begin
			ram_addr.push_back(a);
		end
		ram_addr.push_back(100);
		ram_addr.push_back(`CC_RAM_DEPTH - 1);
		add_entry("rst_word0", K_READ, 0, 0, 0, 0);
		for (int a = `CC_BOARD_LO; a < `CC_BOARD_LO + 8; a++) begin
			add_entry($sformatf("rst_board%0d", a), K_READ, a, 0, 0, 0);
			add_entry($sformatf("rst_pin%0d", a), K_BOARD, a, 0, 0, 0);
		end
		for (int a = 2; a < `CC_CSR_WORDS; a++) begin
			r = $urandom;
			add_entry($sformatf("wr_reg%0d", a), K_WRITE, a, r, 0, 0);
			add_entry($sformatf("rd_reg%0d", a), K_READ, a, 0, r, 0);
			if (a < `CC_BOARD_LO + 8) begin
				add_entry($sformatf("pin_reg%0d", a), K_BOARD, a, 0, r, 0);   // board port too
			end
		end
		foreach (ram_addr[k]) begin
			r = $urandom;
			add_entry($sformatf("wr_ram%0d", ram_addr[k]), K_WRITE, ram_addr[k], r, 0, 0);
			add_entry($sformatf("rd_ram%0d", ram_addr[k]), K_READ, ram_addr[k], 0, r, 0);
		end
		add_entry("run_mixed", K_RUN, 0, 32'h1, 0, 0);
		add_list_checks("mixed", 0);
		add_entry("stop_a", K_STOP, 0, 32'h0, 0, 0);
		add_entry("done_clear_a", K_READ, 0, 0, 0, 0);
		add_entry("run_empty", K_RUN, 0, 32'h1, 0, 1);
		add_list_checks("empty", 1);
		add_entry("stop_b", K_STOP, 0, 32'h0, 0, 0);
		add_entry("done_clear_b", K_READ, 0, 0, 0, 0);
		add_entry("run_second", K_RUN, 0, 32'h1, 0, 2);
		add_list_checks("second", 2);
	endtask

	//==========================================================================
	// bus driver with inputs moved 1 unit after the edge
	//==========================================================================
	task automatic bus_write(input int addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		bus.write     = 1'b1;
		bus.address   = addr[12:0];
		bus.writedata = data;
		@(posedge clk);
		#1;
		bus.write = 1'b0;
	endtask

	task automatic bus_read(input int addr, output bit got);
		int n;
		n = chk.resp_cnt;
		@(posedge clk);
		#1;
		bus.read    = 1'b1;
		bus.address = addr[12:0];
		@(posedge clk);
		#1;
		bus.read = 1'b0;
		for (int t = 0; t < 20 && chk.resp_cnt == n; t++) @(negedge clk);
		got = chk.resp_cnt != n;
	endtask

	task automatic apply_entry(input entry_t e);
		bit got;
		bit done;
		case (e.kind)
			K_WRITE, K_STOP: bus_write(e.addr, e.data);
			K_READ: begin
				chk.expect_read(e.name, e.exp);
				bus_read(e.addr, got);
				if (!got) chk.note_fail(e.name, "no read response before the timeout");
			end
			K_BOARD: chk.check_board_word(e.name, e.addr - `CC_BOARD_LO, e.exp);
			K_RUN: begin
				cur_set = e.set;
				bus_write(0, e.data);
				done = 1'b0;
				for (int p = 0; p < 300 && !done; p++) begin   // poll the done bit
					bus_read(0, got);
					done = got && chk.last_data[`CC_DONE_BIT];
				end
				if (done) chk.note_pass(e.name);
				else chk.note_fail(e.name, "done bit never set before the timeout");
			end
			default: chk.note_fail(e.name, "unknown table entry kind");
		endcase
	endtask

	//==========================================================================
	// LMG model reacting to pins seen at the falling edge
	//==========================================================================
	initial begin
		bit saw_rst;
		bit saw_rd;
		int ptr;
		int done_wait;
		lmg_stat  = '0;
		ptr       = 0;
		done_wait = 0;
		forever begin
			@(negedge clk);
			saw_rst = lmg_ctrl.reset;
			saw_rd  = lmg_ctrl.rden;
			@(posedge clk);
			#1;
			if (saw_rst) begin
				ptr            = 0;
				lmg_stat.empty = 1'b0;
				lmg_stat.done  = 1'b0;
				done_wait      = 3;
			end else if (done_wait > 0) begin
				done_wait--;
				if (done_wait == 0) lmg_stat.done = 1'b1;   // generation finished
			end
			if (saw_rd) begin
				lmg_stat.fifo_word = words[cur_set][ptr];
				ptr++;
				lmg_stat.empty = ptr >= n_words[cur_set];
			end
		end
	end

	initial begin
		arst_n = 1'b0;
		bus    = '0;
		void'($urandom(SEED));
		make_set(0, 2, 1'b0);
		make_set(1, 1, 1'b1);
		make_set(2, 3, 1'b0);
		build_table();
		repeat (3) @(posedge clk);
		#1 arst_n = 1'b1;
		repeat (2) @(posedge clk);
		chk.check_no_pulses("rst_lmg_quiet");
		foreach (table_q[i]) apply_entry(table_q[i]);
		repeat (2) @(posedge clk);
		$display("tests %0d passed %0d failed %0d",
			chk.pass_cnt + chk.fail_cnt, chk.pass_cnt, chk.fail_cnt);
		if (chk.fail_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== chess_ctrl.f ====
+incdir+rtl
rtl/chess_ctrl_pkg.sv
rtl/csr_bank.sv
rtl/move_collector.sv
rtl/move_store.sv
rtl/chess_ctrl_top.sv
verification/tb_clock.sv
verification/chess_ctrl_checker.sv
verification/chess_ctrl_properties.sv
verification/chess_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run for the chess search-assist controller

VERILATOR ?= verilator
TOP       ?= chess_ctrl_tb
FILELIST  ?= chess_ctrl.f
SEED      ?= 32\'hba5a
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) $(EXTRA) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
